//--- filelist.f
rtl/eth_rx_pkg.sv
rtl/eth_rx.sv
rtl/ffcp_rx.sv
rtl/fgp_rx.sv
rtl/bytes_to_colors.sv
rtl/stream_to_memory.sv
rtl/ffcp_video_rx.sv
testbench/ffcp_video_rx_sva.sv
testbench/tb_ffcp_video_rx.sv

//--- rtl/bytes_to_colors.sv
// ----------------------------------------------------------------------
// Packs each three data bytes into two 12-bit colors
// ----------------------------------------------------------------------
module bytes_to_colors (
	input  logic clk,
	input  logic eth_rx_downstream_rst,
	input  logic frame_done,
	input  logic frame_err,
	input  logic data_valid,
	input  logic [eth_rx_pkg::byte_len-1:0] data_byte,
	output logic color_valid,
	output logic [eth_rx_pkg::color_len-1:0] color
);
	import eth_rx_pkg::*;

	logic [1:0] phase;
	logic [byte_len-1:0] held;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			phase <= 2'd0;
			color_valid <= 1'b0;
		end else begin
			color_valid <= 1'b0;
			if (frame_done || frame_err) begin
				phase <= 2'd0;
			end else if (data_valid) begin
				// First byte of a triple only gets held
				color_valid <= (phase != 2'd0);
				phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (data_valid) begin
			held <= data_byte;
			if (phase == 2'd1)
				color <= {held, data_byte[byte_len-1:byte_len/2]};
			else
				color <= {held[byte_len/2-1:0], data_byte};
		end
	end

endmodule

//--- rtl/eth_rx.sv
// ----------------------------------------------------------------------
// RMII receiver: preamble and SFD search, dibit to byte assembly,
// Ethernet header skip with ethertype capture, frame end checks
// ----------------------------------------------------------------------
module eth_rx (
	input  logic clk,
	input  logic eth_rx_downstream_rst,
	input  logic rmii_crsdv,
	input  logic [1:0] rmii_rxd,
	output logic byte_valid,
	output logic [eth_rx_pkg::byte_len-1:0] byte_data,
	output logic ethertype_valid,
	output logic [eth_rx_pkg::ethertype_len-1:0] ethertype,
	output logic frame_done,
	output logic frame_err
);
	import eth_rx_pkg::*;

	eth_rx_state_e state;
	logic [1:0] dibit_cnt;
	logic [eth_byte_cnt_len-1:0] byte_cnt;
	// Three earlier dibits of the byte being assembled
	logic [byte_len-3:0] shift_reg;
	logic [byte_len-1:0] next_byte;
	logic in_frame;

	// LSB dibit arrives first, so the newest dibit lands on top
	assign next_byte = {rmii_rxd, shift_reg};
	assign in_frame = (state == eth_rx_header) || (state == eth_rx_payload);

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			state <= eth_rx_idle;
			dibit_cnt <= '0;
			byte_cnt <= '0;
			byte_valid <= 1'b0;
			ethertype_valid <= 1'b0;
			frame_done <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			ethertype_valid <= 1'b0;
			frame_done <= 1'b0;
			frame_err <= 1'b0;
			case (state)
				eth_rx_idle, eth_rx_preamble: begin
					dibit_cnt <= '0;
					byte_cnt <= '0;
					if (!rmii_crsdv)
						state <= eth_rx_idle;
					else if (rmii_rxd == sfd_last_dibit)
						state <= eth_rx_header;
					else if (rmii_rxd == preamble_dibit)
						state <= eth_rx_preamble;
					else
						state <= eth_rx_drop;
				end
				eth_rx_header, eth_rx_payload: begin
					if (!rmii_crsdv) begin
						state <= eth_rx_idle;
						// Short header or a partial byte at carrier loss
						if (state == eth_rx_header || dibit_cnt != 2'd0)
							frame_err <= 1'b1;
						else
							frame_done <= 1'b1;
					end else begin
						dibit_cnt <= dibit_cnt + 2'd1;
						if (dibit_cnt == 2'd3) begin
							if (state == eth_rx_payload) begin
								byte_valid <= 1'b1;
							end else begin
								byte_cnt <= byte_cnt + 1'b1;
								if (byte_cnt == eth_header_len - 1) begin
									ethertype_valid <= 1'b1;
									state <= eth_rx_payload;
								end
							end
						end
					end
				end
				eth_rx_drop: begin
					if (!rmii_crsdv)
						state <= eth_rx_idle;
				end
				default: state <= eth_rx_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rmii_crsdv && in_frame) begin
			shift_reg <= next_byte[byte_len-1:2];
			if (dibit_cnt == 2'd3) begin
				byte_data <= next_byte;
				// Ethertype is sent high byte first
				if (state == eth_rx_header && byte_cnt == eth_header_len - 2)
					ethertype[ethertype_len-1:byte_len] <= next_byte;
				if (state == eth_rx_header && byte_cnt == eth_header_len - 1)
					ethertype[byte_len-1:0] <= next_byte;
			end
		end
	end

endmodule

//--- rtl/eth_rx_pkg.sv
// ----------------------------------------------------------------------
// Shared constants and types of the Ethernet to video RAM receive path
// Frame layout, FGP sizes, video RAM geometry, FFCP and parser enums
// ----------------------------------------------------------------------
package eth_rx_pkg;

	localparam int byte_len = 8;
	// 4 bits each of red, green, blue
	localparam int color_len = 12;

	// Two MAC addresses plus the ethertype
	localparam int eth_header_len = 14;
	localparam int eth_byte_cnt_len = $clog2(eth_header_len + 1);
	localparam int ethertype_len = 2 * byte_len;
	localparam logic [ethertype_len-1:0] ethertype_ffcp = 16'h88B5;

	// RMII line symbols seen during the preamble
	localparam logic [1:0] preamble_dibit = 2'b01;
	localparam logic [1:0] sfd_last_dibit = 2'b11;

	localparam int fgp_data_len_colors = 16;
	localparam int fgp_data_len_bytes = 24;
	// Offset byte, data bytes, then one saturated value for extra bytes
	localparam int fgp_cnt_len = $clog2(fgp_data_len_bytes + 2);

	localparam int vram_size = 4096;
	localparam int vram_addr_len = $clog2(vram_size);

	localparam int ffcp_index_len = 8;

	typedef enum logic [byte_len-1:0] {
		ffcp_type_ack = 8'd0,
		ffcp_type_syn = 8'd1,
		ffcp_type_msg = 8'd2
	} ffcp_type_e;

	typedef enum logic [2:0] {
		eth_rx_idle,
		eth_rx_preamble,
		eth_rx_header,
		eth_rx_payload,
		// Bad preamble, wait for carrier to drop
		eth_rx_drop
	} eth_rx_state_e;

endpackage

//--- rtl/ffcp_rx.sv
// ----------------------------------------------------------------------
// FFCP receiver: ethertype filter, type and index parse, payload
// forwarding and accept report for SYN and MSG frames
// ----------------------------------------------------------------------
module ffcp_rx (
	input  logic clk,
	input  logic eth_rx_downstream_rst,
	input  logic byte_valid,
	input  logic [eth_rx_pkg::byte_len-1:0] byte_data,
	input  logic ethertype_valid,
	input  logic [eth_rx_pkg::ethertype_len-1:0] ethertype,
	input  logic frame_done,
	input  logic frame_err,
	output logic ffcp_meta_valid,
	output eth_rx_pkg::ffcp_type_e ffcp_type,
	output logic [eth_rx_pkg::ffcp_index_len-1:0] ffcp_index,
	output logic payload_valid,
	output logic [eth_rx_pkg::byte_len-1:0] payload_data,
	output logic frame_accept,
	output logic accept_syn,
	output logic [eth_rx_pkg::ffcp_index_len-1:0] accept_index
);
	import eth_rx_pkg::*;

	logic enable;
	// 0 type byte, 1 index byte, 2 payload
	logic [1:0] position;
	logic buf_valid;
	logic syn_buf;
	logic [ffcp_index_len-1:0] index_buf;
	logic take_byte;

	assign take_byte = byte_valid && enable;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			enable <= 1'b0;
			position <= 2'd0;
			buf_valid <= 1'b0;
			ffcp_meta_valid <= 1'b0;
			payload_valid <= 1'b0;
			frame_accept <= 1'b0;
		end else begin
			ffcp_meta_valid <= 1'b0;
			payload_valid <= 1'b0;
			frame_accept <= 1'b0;
			if (frame_err) begin
				enable <= 1'b0;
				position <= 2'd0;
				buf_valid <= 1'b0;
			end else if (frame_done) begin
				frame_accept <= enable && buf_valid;
				position <= 2'd0;
				buf_valid <= 1'b0;
			end else begin
				if (ethertype_valid)
					enable <= (ethertype == ethertype_ffcp);
				if (take_byte) begin
					case (position)
						2'd0: position <= 2'd1;
						2'd1: begin
							position <= 2'd2;
							ffcp_meta_valid <= 1'b1;
							// ACK frames are never acknowledged
							buf_valid <= (ffcp_type == ffcp_type_syn) ||
								(ffcp_type == ffcp_type_msg);
						end
						default: payload_valid <= 1'b1;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_byte && position == 2'd0)
			ffcp_type <= ffcp_type_e'(byte_data);
		if (take_byte && position == 2'd1) begin
			ffcp_index <= byte_data;
			index_buf <= byte_data;
			syn_buf <= (ffcp_type == ffcp_type_syn);
		end
		if (take_byte)
			payload_data <= byte_data;
		if (frame_done) begin
			accept_syn <= syn_buf;
			accept_index <= index_buf;
		end
	end

endmodule

//--- rtl/ffcp_video_rx.sv
// ----------------------------------------------------------------------
// Receive chain top: RMII pins through FFCP and FGP to the VRAM port
// ----------------------------------------------------------------------
module ffcp_video_rx (
	input  logic clk,
	input  logic eth_rx_downstream_rst,
	input  logic rmii_crsdv,
	input  logic [1:0] rmii_rxd,
	output logic vram_we,
	output logic [eth_rx_pkg::vram_addr_len-1:0] vram_waddr,
	output logic [eth_rx_pkg::color_len-1:0] vram_win,
	output logic ffcp_meta_valid,
	output eth_rx_pkg::ffcp_type_e ffcp_type,
	output logic [eth_rx_pkg::ffcp_index_len-1:0] ffcp_index,
	output logic frame_accept,
	output logic accept_syn,
	output logic [eth_rx_pkg::ffcp_index_len-1:0] accept_index,
	output logic frame_done,
	output logic frame_err
);
	import eth_rx_pkg::*;

	logic byte_valid, ethertype_valid;
	logic [byte_len-1:0] byte_data;
	logic [ethertype_len-1:0] ethertype;
	logic payload_valid, offset_valid, data_valid, color_valid;
	logic [byte_len-1:0] payload_data, offset, data_byte;
	logic [color_len-1:0] color;

	eth_rx u_eth_rx (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.rmii_crsdv(rmii_crsdv), .rmii_rxd(rmii_rxd),
		.byte_valid(byte_valid), .byte_data(byte_data),
		.ethertype_valid(ethertype_valid), .ethertype(ethertype),
		.frame_done(frame_done), .frame_err(frame_err));

	ffcp_rx u_ffcp_rx (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.byte_valid(byte_valid), .byte_data(byte_data),
		.ethertype_valid(ethertype_valid), .ethertype(ethertype),
		.frame_done(frame_done), .frame_err(frame_err),
		.ffcp_meta_valid(ffcp_meta_valid), .ffcp_type(ffcp_type),
		.ffcp_index(ffcp_index),
		.payload_valid(payload_valid), .payload_data(payload_data),
		.frame_accept(frame_accept), .accept_syn(accept_syn),
		.accept_index(accept_index));

	fgp_rx u_fgp_rx (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.frame_done(frame_done), .frame_err(frame_err),
		.payload_valid(payload_valid), .payload_data(payload_data),
		.offset_valid(offset_valid), .offset(offset),
		.data_valid(data_valid), .data_byte(data_byte));

	bytes_to_colors u_bytes_to_colors (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.frame_done(frame_done), .frame_err(frame_err),
		.data_valid(data_valid), .data_byte(data_byte),
		.color_valid(color_valid), .color(color));

	stream_to_memory u_stream_to_memory (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.offset_valid(offset_valid), .offset(offset),
		.color_valid(color_valid), .color(color),
		.vram_we(vram_we), .vram_waddr(vram_waddr), .vram_win(vram_win));

endmodule

//--- rtl/fgp_rx.sv
// ----------------------------------------------------------------------
// FGP receiver: splits the offset byte from at most 24 data bytes
// ----------------------------------------------------------------------
module fgp_rx (
	input  logic clk,
	input  logic eth_rx_downstream_rst,
	input  logic frame_done,
	input  logic frame_err,
	input  logic payload_valid,
	input  logic [eth_rx_pkg::byte_len-1:0] payload_data,
	output logic offset_valid,
	output logic [eth_rx_pkg::byte_len-1:0] offset,
	output logic data_valid,
	output logic [eth_rx_pkg::byte_len-1:0] data_byte
);
	import eth_rx_pkg::*;

	// 0 expects the offset, 1..24 data, then saturates
	logic [fgp_cnt_len-1:0] byte_cnt;
	logic in_limit;

	assign in_limit = (byte_cnt <= fgp_data_len_bytes);

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			byte_cnt <= '0;
			offset_valid <= 1'b0;
			data_valid <= 1'b0;
		end else begin
			offset_valid <= 1'b0;
			data_valid <= 1'b0;
			if (frame_done || frame_err) begin
				byte_cnt <= '0;
			end else if (payload_valid) begin
				if (byte_cnt == '0)
					offset_valid <= 1'b1;
				else if (in_limit)
					data_valid <= 1'b1;
				// Padding beyond the packet is dropped
				if (in_limit)
					byte_cnt <= byte_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (payload_valid) begin
			data_byte <= payload_data;
			if (byte_cnt == '0)
				offset <= payload_data;
		end
	end

endmodule

//--- rtl/stream_to_memory.sv
// ----------------------------------------------------------------------
// Video RAM write port driver, base address set from the FGP offset
// ----------------------------------------------------------------------
module stream_to_memory (
	input  logic clk,
	input  logic eth_rx_downstream_rst,
	input  logic offset_valid,
	input  logic [eth_rx_pkg::byte_len-1:0] offset,
	input  logic color_valid,
	input  logic [eth_rx_pkg::color_len-1:0] color,
	output logic vram_we,
	output logic [eth_rx_pkg::vram_addr_len-1:0] vram_waddr,
	output logic [eth_rx_pkg::color_len-1:0] vram_win
);
	import eth_rx_pkg::*;

	logic [vram_addr_len-1:0] next_addr;

	always_ff @(posedge clk) begin
		if (eth_rx_downstream_rst) begin
			vram_we <= 1'b0;
			next_addr <= '0;
		end else begin
			vram_we <= color_valid;
			// One packet covers 16 colors, wraps at the top of VRAM
			if (offset_valid)
				next_addr <= vram_addr_len'(offset * fgp_data_len_colors);
			else if (color_valid)
				next_addr <= next_addr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (color_valid) begin
			vram_waddr <= next_addr;
			vram_win <= color;
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ffcp_video_rx -f filelist.f

output=$(./obj_dir/Vtb_ffcp_video_rx)
echo "$output"
echo "$output" | grep -qF '*** PASSED ***'

//--- testbench/ffcp_video_rx_sva.sv
// ----------------------------------------------------------------------
// Concurrent assertions on the receive chain top-level ports
// ----------------------------------------------------------------------
module ffcp_video_rx_sva (
	input logic clk,
	input logic eth_rx_downstream_rst,
	input logic vram_we,
	input logic frame_accept,
	input logic frame_done,
	input logic frame_err
);
	timeunit 1ns;
	timeprecision 100ps;

	accept_one_cycle: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		frame_accept |=> !frame_accept)
		else $error("frame_accept stayed high for more than one cycle");

	// A frame ends either cleanly or with an error, never both
	done_err_exclusive: assert property (@(posedge clk) disable iff (eth_rx_downstream_rst)
		!(frame_done && frame_err))
		else $error("frame_done and frame_err high in the same cycle");

	we_low_after_reset: assert property (@(posedge clk)
		eth_rx_downstream_rst |=> !vram_we)
		else $error("vram_we high in the cycle after reset");

endmodule

bind ffcp_video_rx ffcp_video_rx_sva u_ffcp_video_rx_sva (
	.clk(clk),
	.eth_rx_downstream_rst(eth_rx_downstream_rst),
	.vram_we(vram_we),
	.frame_accept(frame_accept),
	.frame_done(frame_done),
	.frame_err(frame_err)
);

//--- testbench/tb_ffcp_video_rx.sv
// ----------------------------------------------------------------------
// Testbench for the RMII to video RAM receive chain: frame stimulus,
// LFSR data, reference write model, output comparator and watchdog
// ----------------------------------------------------------------------
module tb_ffcp_video_rx;
	timeunit 1ns;
	timeprecision 100ps;
	import eth_rx_pkg::*;

	localparam int num_frames = 17;
	localparam int frame_gap = 12;
	localparam int drain_limit = 100;
	// Frames times worst case dibit cycles per frame, clock period, margin
	localparam int timeout_ns = num_frames * 400 * 40 * 2;

	logic clk;
	logic eth_rx_downstream_rst;
	logic rmii_crsdv;
	logic [1:0] rmii_rxd;
	logic vram_we;
	logic [vram_addr_len-1:0] vram_waddr;
	logic [color_len-1:0] vram_win;
	logic ffcp_meta_valid;
	ffcp_type_e ffcp_type;
	logic [ffcp_index_len-1:0] ffcp_index;
	logic frame_accept;
	logic accept_syn;
	logic [ffcp_index_len-1:0] accept_index;
	logic frame_done;
	logic frame_err;

	logic [15:0] lfsr;
	logic [7:0] frame_data [0:31];
	int dibit_budget;
	int errors;
	int test_start_errors;
	int tests_run;
	int tests_failed;
	int err_pulses;
	int done_pulses;

	// Expected DUT responses, oldest first
	logic [vram_addr_len-1:0] exp_addr [$];
	logic [color_len-1:0] exp_color [$];
	logic [7:0] exp_meta_type [$];
	logic [7:0] exp_meta_index [$];
	logic exp_acc_syn [$];
	logic [7:0] exp_acc_index [$];

	ffcp_video_rx u_ffcp_video_rx (
		.clk(clk), .eth_rx_downstream_rst(eth_rx_downstream_rst),
		.rmii_crsdv(rmii_crsdv), .rmii_rxd(rmii_rxd),
		.vram_we(vram_we), .vram_waddr(vram_waddr), .vram_win(vram_win),
		.ffcp_meta_valid(ffcp_meta_valid), .ffcp_type(ffcp_type),
		.ffcp_index(ffcp_index), .frame_accept(frame_accept),
		.accept_syn(accept_syn), .accept_index(accept_index),
		.frame_done(frame_done), .frame_err(frame_err));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		#(timeout_ns);
		$display("Watchdog expired after %0d ns, the tests did not finish", timeout_ns);
		$display("*** FAILED ***");
		$finish;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	// Address starts at offset * 16, each byte triple makes two colors
	function automatic void expected_writes(input logic [7:0] off, input int n_bytes);
		logic [vram_addr_len-1:0] addr;
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		int used;
		addr = {off, 4'h0};
		used = (n_bytes > fgp_data_len_bytes) ? fgp_data_len_bytes : n_bytes;
		for (int i = 0; i + 2 < used; i += 3) begin
			b0 = frame_data[i];
			b1 = frame_data[i+1];
			b2 = frame_data[i+2];
			exp_addr.push_back(addr);
			exp_color.push_back({b0, b1[7:4]});
			addr++;
			exp_addr.push_back(addr);
			exp_color.push_back({b1[3:0], b2});
			addr++;
		end
	endfunction

	// A budget of zero means the carrier has already been cut
	task automatic send_dibit(input logic [1:0] d);
		if (dibit_budget != 0) begin
			@(negedge clk);
			rmii_crsdv = 1'b1;
			rmii_rxd = d;
			if (dibit_budget > 0)
				dibit_budget--;
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		for (int i = 0; i < 4; i++)
			send_dibit(b[2*i +: 2]);
	endtask

	task automatic send_frame(input logic [15:0] etype, input logic [7:0] ftype,
			input logic [7:0] index, input logic [7:0] off, input int n_data, input int cut);
		dibit_budget = -1;
		for (int i = 0; i < 31; i++)
			send_dibit(2'b01);
		send_dibit(2'b11);
		dibit_budget = cut;
		for (int i = 0; i < 6; i++)
			send_byte(8'hFF);
		for (int i = 0; i < 6; i++)
			send_byte(8'h5A);
		send_byte(etype[15:8]);
		send_byte(etype[7:0]);
		send_byte(ftype);
		send_byte(index);
		send_byte(off);
		for (int i = 0; i < n_data; i++)
			send_byte(frame_data[i]);
		// FCS field is carried on the wire but not checked
		for (int i = 0; i < 4; i++)
			send_byte(8'h00);
		@(negedge clk);
		rmii_crsdv = 1'b0;
		rmii_rxd = 2'b00;
		repeat (frame_gap) @(negedge clk);
	endtask

	task automatic send_random_frame(input logic [15:0] etype, input logic [7:0] ftype,
			input int n_data, input int cut);
		logic [7:0] index;
		logic [7:0] off;
		rand_byte(index);
		rand_byte(off);
		for (int i = 0; i < n_data; i++)
			rand_byte(frame_data[i]);
		if (etype == ethertype_ffcp && cut < 0) begin
			exp_meta_type.push_back(ftype);
			exp_meta_index.push_back(index);
			expected_writes(off, n_data);
			if (ftype == ffcp_type_syn || ftype == ffcp_type_msg) begin
				exp_acc_syn.push_back(ftype == ffcp_type_syn);
				exp_acc_index.push_back(index);
			end
		end
		send_frame(etype, ftype, index, off, n_data, cut);
	endtask

	task automatic compare_outputs();
		forever begin
			@(negedge clk);
			if (!eth_rx_downstream_rst) begin
				if (vram_we) begin
					if (exp_addr.size() == 0) begin
						$display("Unexpected video RAM write at address %h", vram_waddr);
						errors++;
					end else begin
						if (vram_waddr !== exp_addr[0]) begin
							$display("Mismatch vram_waddr: expected %h, actual %h",
								exp_addr[0], vram_waddr);
							errors++;
						end
						if (vram_win !== exp_color[0]) begin
							$display("Mismatch vram_win: expected %h, actual %h",
								exp_color[0], vram_win);
							errors++;
						end
						void'(exp_addr.pop_front());
						void'(exp_color.pop_front());
					end
				end
				if (ffcp_meta_valid) begin
					if (exp_meta_type.size() == 0) begin
						$display("Unexpected ffcp_meta_valid pulse");
						errors++;
					end else begin
						if (ffcp_type !== exp_meta_type[0]) begin
							$display("Mismatch ffcp_type: expected %h, actual %h",
								exp_meta_type[0], ffcp_type);
							errors++;
						end
						if (ffcp_index !== exp_meta_index[0]) begin
							$display("Mismatch ffcp_index: expected %h, actual %h",
								exp_meta_index[0], ffcp_index);
							errors++;
						end
						void'(exp_meta_type.pop_front());
						void'(exp_meta_index.pop_front());
					end
				end
				if (frame_accept) begin
					if (exp_acc_index.size() == 0) begin
						$display("Unexpected frame_accept pulse");
						errors++;
					end else begin
						if (accept_syn !== exp_acc_syn[0]) begin
							$display("Mismatch accept_syn: expected %h, actual %h",
								exp_acc_syn[0], accept_syn);
							errors++;
						end
						if (accept_index !== exp_acc_index[0]) begin
							$display("Mismatch accept_index: expected %h, actual %h",
								exp_acc_index[0], accept_index);
							errors++;
						end
						void'(exp_acc_syn.pop_front());
						void'(exp_acc_index.pop_front());
					end
				end
				if (frame_err)
					err_pulses++;
				if (frame_done)
					done_pulses++;
			end
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while ((exp_addr.size() != 0 || exp_meta_type.size() != 0 ||
				exp_acc_index.size() != 0) && n < drain_limit) begin
			@(negedge clk);
			n++;
		end
		if (n >= drain_limit) begin
			$display("Outputs missing: %0d writes, %0d meta and %0d accept pulses never came",
				exp_addr.size(), exp_meta_type.size(), exp_acc_index.size());
			errors++;
			exp_addr.delete();
			exp_color.delete();
			exp_meta_type.delete();
			exp_meta_index.delete();
			exp_acc_syn.delete();
			exp_acc_index.delete();
		end
	endtask

	task automatic report_test(input string name, input int exp_err, input int exp_done);
		wait_drained();
		if (err_pulses != exp_err) begin
			$display("Expected %0d frame_err pulses in %s but saw %0d", exp_err, name, err_pulses);
			errors++;
		end
		if (done_pulses != exp_done) begin
			$display("Expected %0d frame_done pulses in %s but saw %0d",
				exp_done, name, done_pulses);
			errors++;
		end
		tests_run++;
		if (errors == test_start_errors) begin
			$display("ok   %s", name);
		end else begin
			$display("FAIL %s", name);
			tests_failed++;
		end
		err_pulses = 0;
		done_pulses = 0;
		test_start_errors = errors;
	endtask

	initial begin
		eth_rx_downstream_rst = 1'b1;
		rmii_crsdv = 1'b0;
		rmii_rxd = 2'b00;
		lfsr = 16'd445;
		dibit_budget = -1;
		errors = 0;
		test_start_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		err_pulses = 0;
		done_pulses = 0;
		fork
			compare_outputs();
		join_none
		repeat (3) @(negedge clk);
		eth_rx_downstream_rst = 1'b0;
		repeat (2) @(negedge clk);

		send_random_frame(ethertype_ffcp, ffcp_type_msg, 24, -1);
		report_test("msg frame writes, meta and accept", 0, 1);
		send_random_frame(ethertype_ffcp, ffcp_type_syn, 24, -1);
		send_random_frame(ethertype_ffcp, ffcp_type_ack, 24, -1);
		report_test("syn and ack frames", 0, 2);
		send_random_frame(16'h0800, ffcp_type_msg, 24, -1);
		report_test("non-ffcp ethertype filtered", 0, 1);
		// 13 dibits after the SFD ends inside the fourth MAC byte
		send_random_frame(ethertype_ffcp, ffcp_type_msg, 24, 13);
		send_random_frame(ethertype_ffcp, ffcp_type_msg, 24, -1);
		report_test("truncated frame then good frame", 1, 1);
		send_random_frame(ethertype_ffcp, ffcp_type_msg, 30, -1);
		report_test("padded frame limited to 16 writes", 0, 1);
		for (int i = 0; i < 10; i++)
			send_random_frame(ethertype_ffcp, ffcp_type_msg, 24, -1);
		report_test("ten back-to-back msg frames", 0, 10);

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
